/* cnn_host_bridge.f */
rtl/cnn_pkg.sv
rtl/sync_fifo.sv
rtl/block_throttle.sv
rtl/scratch_mem.sv
rtl/dma_port.sv
rtl/csb.sv
rtl/pool_engine.sv
rtl/cnn_host_bridge.sv
bench/tb_cnn_host_bridge.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_cnn_host_bridge -f cnn_host_bridge.f \
	&& ./obj_dir/Vtb_cnn_host_bridge > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation result: fail"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation result: no pass line"; exit 1; }
echo "simulation result: pass"
exit 0

/* bench/tb_cnn_host_bridge.sv */
`timescale 1ns/100ps

module tb_cnn_host_bridge;
	import cnn_pkg::*;

	localparam int TIMEOUT = 4000;                  // cycles allowed per wait
	localparam int IN_LIMIT = FIFO_SIZE - BUFFER_HEADROOM - BLOCK_SIZE;
	localparam int W_IN_READY = 0;
	localparam int W_OUT_READY = 1;
	localparam int W_IN_EMPTY = 2;
	localparam int W_OUT_WORD = 3;

	logic okClk;
	logic rst;
	host_ctrl_t ctrl;
	logic pi_write;
	word_t pi_data;
	logic po_read;
	logic pipe_in_ready;
	logic pipe_out_ready;
	word_t po_data;
	elem_t result;
	logic result_valid;
	logic irq;
	status_t status;

	word_t scoreboard[$];                           // expected pipe-out words in order
	elem_t results[$];
	int errors;
	int tests_run;
	int irq_seen;
	bit po_leak;
	bit run_seen;

	cnn_host_bridge #(
		.FIFO_SIZE(FIFO_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .BUFFER_HEADROOM(BUFFER_HEADROOM)
	) cnn_host_bridge_inst (
		.okClk(okClk), .rst(rst), .ctrl(ctrl), .pi_write(pi_write), .pi_data(pi_data),
		.pipe_in_ready(pipe_in_ready), .po_read(po_read), .po_data(po_data),
		.pipe_out_ready(pipe_out_ready), .result(result), .result_valid(result_valid),
		.irq(irq), .status(status)
	);

	initial begin
		okClk = 1'b0;
		forever #4 okClk = ~okClk;                  // 8 ns period
	end

	// --------------------------------------------------
	// helpers
	// --------------------------------------------------
	task automatic tick();
		@(posedge okClk);
		#1;                                         // drive and sample past the edge
	endtask

	task automatic check_value(input string name, input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAILED %s %s expected %h actual %h", name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input string name, input bit cond, input string what);
		assert (cond) else begin
			$display("%s: %s", name, what);
			errors++;
		end
	endtask

	task automatic report_timeout(input string name, input string what);
		$display("%s: timed out waiting for %s", name, what);
		errors++;
	endtask

	function automatic bit cond_met(input int sel);
		case (sel)
			W_IN_READY: return pipe_in_ready;
			W_OUT_READY: return pipe_out_ready;
			W_IN_EMPTY: return status.pipe_in_empty;
			default: return !status.pipe_out_empty; // a word waits at po_data
		endcase
	endfunction

	task automatic wait_until(input string name, input int sel, input string what);
		int n;
		n = 0;
		while (!cond_met(sel) && n < TIMEOUT) begin
			tick();
			n++;
		end
		if (!cond_met(sel)) begin
			report_timeout(name, what);
		end
	endtask

	function automatic word_t make_cmd(input logic [2:0] op, input int n);
		return {op, 13'd0, n[15:0]};
	endfunction

	task automatic send_word(input string name, input word_t w);
		wait_until(name, W_IN_READY, "pipe_in_ready");
		pi_write = 1'b1;
		pi_data = w;
		tick();
		pi_write = 1'b0;
	endtask

	task automatic send_random(input string name, input bit keep);
		word_t w;
		w = $urandom;
		send_word(name, w);
		if (keep) begin
			scoreboard.push_back(w);
		end
	endtask

	// command word followed by n data words and their reference max and sum
	task automatic send_pool_op(input string name, input logic [2:0] op, input int n,
			output elem_t mx, output elem_t sum);
		word_t w;
		elem_t e;
		mx = elem_t'(16'h8000);
		sum = '0;
		send_word(name, make_cmd(op, n));
		for (int i = 0; i < n; i++) begin
			w = $urandom;
			e = elem_t'(w[15:0]);
			if (e > mx) begin
				mx = e;
			end
			sum = sum + e;                          // wraps modulo 2**16
			send_word(name, w);
		end
	endtask

	task automatic drain_pipe_out(input string name);
		int idle;
		word_t exp;
		idle = 0;
		while (scoreboard.size() > 0 && idle < TIMEOUT) begin
			if (!status.pipe_out_empty) begin
				exp = scoreboard.pop_front();
				check_value(name, "po_data", exp, po_data);
				po_read = 1'b1;
				idle = 0;
			end else begin
				po_read = 1'b0;
				idle++;
			end
			tick();
		end
		po_read = 1'b0;
		if (scoreboard.size() > 0) begin
			report_timeout(name, "pipe-out words");
		end
	endtask

	task automatic sample_ops();
		if (result_valid) begin
			results.push_back(result);
		end
		if (irq) begin
			irq_seen++;
		end
		if (status.op_run) begin
			run_seen = 1'b1;
		end
		if (!status.pipe_out_empty) begin
			po_leak = 1'b1;
		end
		tick();
	endtask

	task automatic watch_ops(input string name, input int want);
		int n;
		results.delete();
		irq_seen = 0;
		po_leak = 1'b0;
		run_seen = 1'b0;
		n = 0;
		while (irq_seen < want && n < TIMEOUT) begin
			sample_ops();
			n++;
		end
		if (irq_seen < want) begin
			report_timeout(name, "irq");
		end
		repeat (40) sample_ops();                   // catch late or extra pulses
		check_value(name, "irq pulses", want, irq_seen);
		check_value(name, "result_valid pulses", want, results.size());
		check_true(name, !po_leak, "a word reached pipe-out during an operation");
		check_true(name, run_seen, "op_run never rose during the operation");
		check_value(name, "op_run", 0, 32'(status.op_run));
		check_value(name, "cmd_empty", 1, 32'(status.cmd_empty));
		check_value(name, "data_empty", 1, 32'(status.data_empty));
	endtask

	task automatic pulse_pipe_rst();
		ctrl = '0;
		ctrl.pipe_rst = 1'b1;
		tick();
		ctrl = '0;
	endtask

	task automatic finish_test(input string name, input int mark);
		tests_run++;
		$display("test %s finished with %0d error(s)", name, errors - mark);
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		int mark;
		int accepted;
		int n;
		elem_t mx;
		elem_t sum;
		elem_t first_sum;
		rst = 1'b1;
		ctrl = '0;
		pi_write = 1'b0;
		pi_data = '0;
		po_read = 1'b0;
		errors = 0;
		tests_run = 0;
		void'($urandom(66787));
		repeat (16) @(posedge okClk);
		#1;
		rst = 1'b0;
		tick();

		mark = errors;
		check_value("reset_state", "pipe_out_ready", 0, 32'(pipe_out_ready));
		check_value("reset_state", "irq", 0, 32'(irq));
		check_value("reset_state", "result_valid", 0, 32'(result_valid));
		check_value("reset_state", "pipe_in_empty", 1, 32'(status.pipe_in_empty));
		check_value("reset_state", "pipe_out_empty", 1, 32'(status.pipe_out_empty));
		check_value("reset_state", "op_run", 0, 32'(status.op_run));
		check_value("reset_state", "pipe_in_full", 0, 32'(status.pipe_in_full));
		check_value("reset_state", "pipe_out_full", 0, 32'(status.pipe_out_full));
		check_value("reset_state", "cmd_empty", 1, 32'(status.cmd_empty));
		check_value("reset_state", "data_empty", 1, 32'(status.data_empty));
		check_value("reset_state", "spare", 0, 32'(status.spare));
		check_value("reset_state", "pipe_in_ready", 1, 32'(pipe_in_ready));
		finish_test("reset_state", mark);

		mark = errors;
		ctrl = '0;
		ctrl.pipe_write = 1'b1;
		ctrl.pipe_read = 1'b1;
		repeat (256) send_random("loopback_order", 1'b1);
		wait_until("loopback_order", W_OUT_READY, "pipe_out_ready");
		drain_pipe_out("loopback_order");
		repeat (10) tick();
		check_value("loopback_order", "pipe_out_empty", 1, 32'(status.pipe_out_empty));
		ctrl = '0;
		finish_test("loopback_order", mark);

		mark = errors;
		accepted = 0;
		n = 0;
		while (pipe_in_ready && n < TIMEOUT) begin
			pi_write = 1'b1;
			pi_data = $urandom;
			accepted++;
			tick();
			n++;
		end
		pi_write = 1'b0;
		if (pipe_in_ready) begin
			report_timeout("pipe_in_throttle", "pipe_in_ready to fall");
		end
		check_true("pipe_in_throttle", accepted > IN_LIMIT,
			$sformatf("pipe_in_ready fell early after %0d words", accepted));
		check_true("pipe_in_throttle", accepted <= IN_LIMIT + 4,
			$sformatf("pipe_in_ready fell late after %0d words", accepted));
		check_value("pipe_in_throttle", "pipe_in_full", 0, 32'(status.pipe_in_full));
		ctrl.pipe_write = 1'b1;                     // drain into scratch memory
		wait_until("pipe_in_throttle", W_IN_READY, "pipe_in_ready to rise");
		wait_until("pipe_in_throttle", W_IN_EMPTY, "pipe-in to drain");
		pulse_pipe_rst();                           // drop the unread words
		finish_test("pipe_in_throttle", mark);

		mark = errors;
		ctrl = '0;
		ctrl.op_en = 1'b1;
		ctrl.pipe_write = 1'b1;
		send_pool_op("maxpool_op", OP_MAXPOOL, 5, mx, sum);
		watch_ops("maxpool_op", 1);
		if (results.size() == 1) begin
			check_value("maxpool_op", "result", {16'h0, mx}, {16'h0, results[0]});
		end
		finish_test("maxpool_op", mark);

		mark = errors;
		send_word("avepool_skip", make_cmd(OP_CONV, 4));
		send_pool_op("avepool_skip", OP_AVEPOOL, 4, mx, sum);
		first_sum = sum;
		send_pool_op("avepool_skip", OP_MAXPOOL, 3, mx, sum);
		watch_ops("avepool_skip", 2);
		if (results.size() == 2) begin
			check_value("avepool_skip", "sum", {16'h0, first_sum}, {16'h0, results[0]});
			check_value("avepool_skip", "max", {16'h0, mx}, {16'h0, results[1]});
		end
		ctrl = '0;
		finish_test("avepool_skip", mark);

		mark = errors;
		ctrl.pipe_write = 1'b1;
		ctrl.pipe_read = 1'b1;
		repeat (8) send_random("pipe_reset", 1'b0);
		wait_until("pipe_reset", W_OUT_WORD, "old words on pipe-out");
		ctrl.pipe_read = 1'b0;
		repeat (8) send_random("pipe_reset", 1'b0);
		ctrl.pipe_write = 1'b0;
		repeat (8) send_random("pipe_reset", 1'b0);
		pulse_pipe_rst();
		check_value("pipe_reset", "pipe_in_empty", 1, 32'(status.pipe_in_empty));
		check_value("pipe_reset", "pipe_out_empty", 1, 32'(status.pipe_out_empty));
		scoreboard.delete();
		ctrl.pipe_write = 1'b1;
		ctrl.pipe_read = 1'b1;
		repeat (10) send_random("pipe_reset", 1'b1);
		drain_pipe_out("pipe_reset");
		repeat (30) tick();
		check_value("pipe_reset", "pipe_out_empty", 1, 32'(status.pipe_out_empty));
		ctrl = '0;
		finish_test("pipe_reset", mark);

		$display("%0d tests run, %0d check(s) failed", tests_run, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* rtl/cnn_host_bridge.sv */
`timescale 1ns/100ps

module cnn_host_bridge #(
	parameter int FIFO_SIZE = cnn_pkg::FIFO_SIZE,
	parameter int BLOCK_SIZE = cnn_pkg::BLOCK_SIZE,
	parameter int BUFFER_HEADROOM = cnn_pkg::BUFFER_HEADROOM
) (
	input  logic                okClk,
	input  logic                rst,
	input  cnn_pkg::host_ctrl_t ctrl,
	input  logic                pi_write,
	input  cnn_pkg::word_t      pi_data,
	output logic                pipe_in_ready,
	input  logic                po_read,
	output cnn_pkg::word_t      po_data,
	output logic                pipe_out_ready,
	output cnn_pkg::elem_t      result,
	output logic                result_valid,
	output logic                irq,
	output cnn_pkg::status_t    status
);
	import cnn_pkg::*;

	fifo_wr_t pi_wr;
	fifo_wr_t po_wr;
	fifo_wr_t cmd_wr;
	fifo_wr_t data_wr;
	word_t ib_data;
	word_t cmd_word;
	word_t data_word;
	count_t pi_count;
	count_t po_count;
	count_t cmd_count;
	count_t data_count;
	logic pi_empty;
	logic pi_full;
	logic po_empty;
	logic po_full;
	logic ib_re;
	logic cmd_empty;
	logic cmd_rd_en;
	logic data_empty;
	logic data_rd_en;
	logic op_run;
	logic start;
	logic done;
	op_type_e op_type;
	op_num_t op_num;

	assign pi_wr = '{we: pi_write, data: pi_data};

	// status bits are active high
	assign status = '{
		pipe_in_full:   pi_full,
		pipe_in_empty:  pi_empty,
		pipe_out_full:  po_full,
		pipe_out_empty: po_empty,
		op_run:         op_run,
		cmd_empty:      cmd_empty,
		data_empty:     data_empty,
		spare:          1'b0
	};

	// --------------------------------------------------
	// host pipes
	// --------------------------------------------------
	sync_fifo #(.FIFO_SIZE(FIFO_SIZE)) pipe_in_fifo (
		.okClk(okClk), .rst(rst), .clr(ctrl.pipe_rst), .wr(pi_wr), .rd_en(ib_re),
		.dout(ib_data), .empty(pi_empty), .full(pi_full), .count(pi_count)
	);

	sync_fifo #(.FIFO_SIZE(FIFO_SIZE)) pipe_out_fifo (
		.okClk(okClk), .rst(rst), .clr(ctrl.pipe_rst), .wr(po_wr), .rd_en(po_read),
		.dout(po_data), .empty(po_empty), .full(po_full), .count(po_count)
	);

	block_throttle #(
		.FIFO_SIZE(FIFO_SIZE), .BLOCK_SIZE(BLOCK_SIZE), .BUFFER_HEADROOM(BUFFER_HEADROOM)
	) block_throttle_inst (
		.okClk(okClk), .rst(rst), .in_count(pi_count), .out_count(po_count),
		.pipe_in_ready(pipe_in_ready), .pipe_out_ready(pipe_out_ready)
	);

	dma_port dma_port_inst (
		.okClk(okClk), .rst(rst), .ctrl(ctrl),
		.ib_data(ib_data), .ib_empty(pi_empty), .ib_re(ib_re),
		.op_run(op_run), .op_num(op_num),
		.out_count(po_count), .cmd_count(cmd_count), .data_count(data_count),
		.po_wr(po_wr), .cmd_wr(cmd_wr), .data_wr(data_wr)
	);

	// --------------------------------------------------
	// command and pool path
	// --------------------------------------------------
	sync_fifo #(.FIFO_SIZE(FIFO_SIZE)) cmd_fifo (
		.okClk(okClk), .rst(rst), .clr(ctrl.csb_rst), .wr(cmd_wr), .rd_en(cmd_rd_en),
		.dout(cmd_word), .empty(cmd_empty), .full(), .count(cmd_count)
	);

	sync_fifo #(.FIFO_SIZE(FIFO_SIZE)) data_fifo (
		.okClk(okClk), .rst(rst), .clr(ctrl.csb_rst), .wr(data_wr), .rd_en(data_rd_en),
		.dout(data_word), .empty(data_empty), .full(), .count(data_count)
	);

	csb csb_inst (
		.okClk(okClk), .rst(rst), .ctrl(ctrl),
		.cmd(cmd_word), .cmd_empty(cmd_empty), .cmd_rd_en(cmd_rd_en),
		.op_type(op_type), .op_num(op_num), .op_run(op_run), .start(start),
		.done(done), .irq(irq)
	);

	pool_engine pool_engine_inst (
		.okClk(okClk), .rst(rst), .clr(ctrl.csb_rst), .start(start),
		.op_type(op_type), .op_num(op_num),
		.data(data_word), .data_empty(data_empty), .data_rd_en(data_rd_en),
		.result(result), .result_valid(result_valid), .done(done)
	);

endmodule

/* rtl/pool_engine.sv */
`timescale 1ns/100ps

module pool_engine (
	input  logic              okClk,
	input  logic              rst,
	input  logic              clr,
	input  logic              start,
	input  cnn_pkg::op_type_e op_type,
	input  cnn_pkg::op_num_t  op_num,
	input  cnn_pkg::word_t    data,
	input  logic              data_empty,
	output logic              data_rd_en,
	output cnn_pkg::elem_t    result,
	output logic              result_valid,
	output logic              done
);
	import cnn_pkg::*;

	op_num_t remaining;                             // words still to fold
	elem_t acc;
	elem_t elem;
	elem_t folded;
	logic done_q;

	assign elem = data[15:0];
	assign data_rd_en = (remaining != '0) && !data_empty;

	// signed max for maxpool, wrapping sum for avepool
	assign folded = (op_type == OP_MAXPOOL) ? ((elem > acc) ? elem : acc) : acc + elem;

	assign result = acc;
	assign result_valid = done_q;
	assign done = done_q;

	always_ff @(posedge okClk) begin
		if (rst || clr) begin
			remaining <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= data_rd_en && (remaining == op_num_t'(1));
			if (start) begin
				remaining <= op_num;
			end else if (data_rd_en) begin
				remaining <= remaining - 1'b1;
			end
		end
	end

	// --------------------------------------------------
	// accumulator
	// --------------------------------------------------
	always_ff @(posedge okClk) begin
		if (start) begin
			acc <= (op_type == OP_MAXPOOL) ? elem_t'(16'h8000) : elem_t'(0); // most negative
		end else if (data_rd_en) begin
			acc <= folded;
		end
	end

endmodule

/* rtl/csb.sv */
`timescale 1ns/100ps

module csb (
	input  logic                okClk,
	input  logic                rst,
	input  cnn_pkg::host_ctrl_t ctrl,
	input  cnn_pkg::word_t      cmd,
	input  logic                cmd_empty,
	output logic                cmd_rd_en,
	output cnn_pkg::op_type_e   op_type,
	output cnn_pkg::op_num_t    op_num,
	output logic                op_run,
	output logic                start,
	input  logic                done,
	output logic                irq
);
	import cnn_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		FETCH,
		RUN,
		FINISH
	} state_e;

	state_e state;
	cmd_t cur;
	logic supported;

	assign cur = cmd;
	assign supported = ((cur.op_type == OP_MAXPOOL) || (cur.op_type == OP_AVEPOOL))
		&& (cur.op_num != '0);                  // conv and empty ops are dropped

	assign cmd_rd_en = (state == FETCH);            // head word is popped either way
	assign op_run = (state == RUN);
	assign irq = (state == FINISH);

	// --------------------------------------------------
	// command fsm
	// --------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst || ctrl.csb_rst) begin
			state <= IDLE;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			case (state)
				IDLE: begin
					if (ctrl.op_en && !cmd_empty) begin
						state <= FETCH;
					end
				end
				FETCH: begin
					if (supported) begin
						state <= RUN;
						start <= 1'b1;          // engine loads on the next edge
					end else begin
						state <= IDLE;
					end
				end
				RUN: begin
					if (done) begin
						state <= FINISH;
					end
				end
				FINISH: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// decoded command held for the whole operation
	always_ff @(posedge okClk) begin
		if ((state == FETCH) && supported) begin
			op_type <= cur.op_type;
			op_num <= cur.op_num;
		end
	end

endmodule

/* rtl/dma_port.sv */
`timescale 1ns/100ps

module dma_port (
	input  logic                okClk,
	input  logic                rst,
	input  cnn_pkg::host_ctrl_t ctrl,
	input  cnn_pkg::word_t      ib_data,
	input  logic                ib_empty,
	output logic                ib_re,
	input  logic                op_run,
	input  cnn_pkg::op_num_t    op_num,
	input  cnn_pkg::count_t     out_count,
	input  cnn_pkg::count_t     cmd_count,
	input  cnn_pkg::count_t     data_count,
	output cnn_pkg::fifo_wr_t   po_wr,
	output cnn_pkg::fifo_wr_t   cmd_wr,
	output cnn_pkg::fifo_wr_t   data_wr
);
	import cnn_pkg::*;

	localparam int OUT_LIMIT = FIFO_SIZE - BUFFER_HEADROOM;

	typedef enum logic [1:0] {
		DST_PO,
		DST_CMD,
		DST_DATA
	} dest_e;

	mem_addr_t wr_addr;
	mem_addr_t rd_addr;
	word_t rd_data;
	logic reads_en;
	logic admit;
	logic issue;
	logic in_flight;
	dest_e dest;
	dest_e flight_dest;
	op_num_t routed;                                // data words sent this operation

	// --------------------------------------------------
	// write side, pipe-in to scratch memory
	// --------------------------------------------------
	assign ib_re = ctrl.pipe_write && !ib_empty;

	scratch_mem scratch_mem_inst (
		.okClk (okClk),
		.we    (ib_re),
		.waddr (wr_addr),
		.wdata (ib_data),
		.raddr (rd_addr),
		.rdata (rd_data)
	);

	// --------------------------------------------------
	// read side, destination and admission
	// --------------------------------------------------
	assign reads_en = ctrl.pipe_read || ctrl.op_en;

	always_comb begin
		if (!ctrl.op_en) begin
			dest = DST_PO;                          // plain transfer mode
			admit = (int'(out_count) < OUT_LIMIT);
		end else if (op_run) begin
			dest = DST_DATA;
			admit = (routed < op_num) && (int'(data_count) < OUT_LIMIT);
		end else begin
			dest = DST_CMD;                         // one command at a time
			admit = (cmd_count == '0) && !in_flight;
		end
	end

	assign issue = reads_en && (rd_addr != wr_addr) && admit;

	// word read last cycle lands where it was aimed at issue time
	assign po_wr = '{we: in_flight && (flight_dest == DST_PO), data: rd_data};
	assign cmd_wr = '{we: in_flight && (flight_dest == DST_CMD), data: rd_data};
	assign data_wr = '{we: in_flight && (flight_dest == DST_DATA), data: rd_data};

	always_ff @(posedge okClk) begin
		if (rst || ctrl.pipe_rst) begin
			wr_addr <= '0;
			rd_addr <= '0;
			in_flight <= 1'b0;
			flight_dest <= DST_PO;
		end else begin
			if (ib_re) begin
				wr_addr <= wr_addr + 1'b1;      // wraps at 1024
			end
			if (issue) begin
				rd_addr <= rd_addr + 1'b1;
			end
			in_flight <= issue;
			flight_dest <= dest;
		end
	end

	always_ff @(posedge okClk) begin
		if (rst || !op_run) begin
			routed <= '0;                           // rearmed between operations
		end else if (issue && (dest == DST_DATA)) begin
			routed <= routed + 1'b1;
		end
	end

endmodule

/* rtl/scratch_mem.sv */
`timescale 1ns/100ps

module scratch_mem (
	input  logic               okClk,
	input  logic               we,
	input  cnn_pkg::mem_addr_t waddr,
	input  cnn_pkg::word_t     wdata,
	input  cnn_pkg::mem_addr_t raddr,
	output cnn_pkg::word_t     rdata
);
	import cnn_pkg::*;

	word_t ram [0:(1 << MEM_ADDR_W)-1];             // stands in for the ddr2 device

	always_ff @(posedge okClk) begin
		if (we) begin
			ram[waddr] <= wdata;
		end
		rdata <= ram[raddr];                        // one cycle read latency
	end

endmodule

/* rtl/block_throttle.sv */
`timescale 1ns/100ps

module block_throttle #(
	parameter int FIFO_SIZE = cnn_pkg::FIFO_SIZE,
	parameter int BLOCK_SIZE = cnn_pkg::BLOCK_SIZE,
	parameter int BUFFER_HEADROOM = cnn_pkg::BUFFER_HEADROOM
) (
	input  logic            okClk,
	input  logic            rst,
	input  cnn_pkg::count_t in_count,
	input  cnn_pkg::count_t out_count,
	output logic            pipe_in_ready,
	output logic            pipe_out_ready
);

	// room for one more whole block, with margin for the count lag
	localparam int IN_LIMIT = FIFO_SIZE - BUFFER_HEADROOM - BLOCK_SIZE;

	always_ff @(posedge okClk) begin
		if (rst) begin
			pipe_in_ready <= 1'b0;
			pipe_out_ready <= 1'b0;
		end else begin
			pipe_in_ready <= (int'(in_count) <= IN_LIMIT);
			pipe_out_ready <= (int'(out_count) >= BLOCK_SIZE); // a full block waits
		end
	end

endmodule

/* rtl/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
	parameter int FIFO_SIZE = cnn_pkg::FIFO_SIZE
) (
	input  logic              okClk,
	input  logic              rst,
	input  logic              clr,
	input  cnn_pkg::fifo_wr_t wr,
	input  logic              rd_en,
	output cnn_pkg::word_t    dout,
	output logic              empty,
	output logic              full,
	output cnn_pkg::count_t   count
);
	import cnn_pkg::*;

	localparam int PTR_W = $clog2(FIFO_SIZE + 1);

	word_t mem [0:FIFO_SIZE];                       // one spare slot beyond usable depth
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic do_wr;
	logic do_rd;

	assign full = (count == count_t'(FIFO_SIZE));
	assign empty = (count == '0);
	assign do_wr = wr.we && !full;                  // writes to a full fifo are dropped
	assign do_rd = rd_en && !empty;
	assign dout = mem[rd_ptr];                      // show-ahead head word

	always_ff @(posedge okClk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr.data;
		end
	end

	// --------------------------------------------------
	// pointers and fill count
	// --------------------------------------------------
	always_ff @(posedge okClk) begin
		if (rst || clr) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == PTR_W'(FIFO_SIZE)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == PTR_W'(FIFO_SIZE)) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;        // idle or simultaneous push and pop
			endcase
		end
	end

endmodule

/* rtl/cnn_pkg.sv */
package cnn_pkg;

	// --------------------------------------------------
	// data widths
	// --------------------------------------------------
	typedef logic [31:0] word_t;                    // pipe, fifo and memory word
	typedef logic signed [15:0] elem_t;             // feature element, low half of a word
	typedef logic [9:0] count_t;                    // fifo fill count
	typedef logic [15:0] op_num_t;                  // elements per operation

	// --------------------------------------------------
	// sizes and limits
	// --------------------------------------------------
	localparam int FIFO_SIZE = 1023;                // usable words per fifo
	localparam int BLOCK_SIZE = 128;                // 512 byte host block
	localparam int BUFFER_HEADROOM = 20;            // slack for count latency
	localparam int MEM_ADDR_W = 10;                 // 1024 word scratch store

	typedef logic [MEM_ADDR_W-1:0] mem_addr_t;

	typedef enum logic [2:0] {
		OP_CONV    = 3'd0,
		OP_MAXPOOL = 3'd1,
		OP_AVEPOOL = 3'd2
	} op_type_e;

	typedef struct packed {
		op_type_e   op_type;                        // bits 31:29
		logic [12:0] rsvd;
		op_num_t    op_num;                         // element count
	} cmd_t;

	// host control wire, bit 4 down to bit 0
	typedef struct packed {
		logic op_en;
		logic csb_rst;
		logic pipe_rst;
		logic pipe_write;
		logic pipe_read;
	} host_ctrl_t;

	typedef struct packed {
		logic  we;
		word_t data;
	} fifo_wr_t;

	typedef struct packed {
		logic pipe_in_full;
		logic pipe_in_empty;
		logic pipe_out_full;
		logic pipe_out_empty;
		logic op_run;
		logic cmd_empty;
		logic data_empty;
		logic spare;                                // always zero
	} status_t;

endpackage
